/* Makefile */
VERILATOR ?= verilator
TOP       ?= bdHostTop_tb
FLIST     ?= bdHostTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

/* axilPipeSlave.sv */
`timescale 1ns/1ps

module axilPipeSlave import bdHostPkg::*; #(
  parameter int inDepth = 8
) (
  input  logic               sysClk,
  input  logic               rst,
  input  axilReq             axiIn,
  output axilRsp             axiOut,
  output logic               cmdValid,
  output cmdWord             cmdData,
  input  logic               cmdReady,
  output logic [4:0]         regRdIdx,
  output logic [4:0]         chanRdIdx,
  input  logic [15:0]        regRdData,
  input  logic [15:0]        chanRdData,
  input  logic               outValid,
  input  logic [31:0]        outData,
  input  logic [cntBits-1:0] outCount,
  output logic               outPop
);

  localparam int ptrW = $clog2(inDepth);
  localparam logic [ptrW:0] inFull = (ptrW+1)'(inDepth);

  logic            liveQ;     // Holds readies low through reset
  cmdWord          inMem [inDepth];
  logic [ptrW-1:0] inWrPtr;
  logic [ptrW-1:0] inRdPtr;
  logic [ptrW:0]   inCount;
  logic            inPush;
  logic            inPop;
  logic            wrIsPipe;
  logic            wrAccept;
  logic            bValidQ;
  logic [1:0]      bRespQ;
  logic            arReady;
  logic            rdFire;
  logic            rValidQ;
  logic [1:0]      rRespQ;
  logic [31:0]     rDataQ;
  logic [31:0]     rdData;
  logic [1:0]      rdResp;
  logic            rdPop;

  always_ff @(posedge sysClk) begin
    if (rst) liveQ <= 1'b0;
    else     liveQ <= 1'b1;
  end

  // ------------------------------------------------------------------------
  // Write channel, address and data taken together
  // ------------------------------------------------------------------------
  assign wrIsPipe = (axiIn.awAddr == addrPipeIn);
  assign wrAccept = liveQ && axiIn.awValid && axiIn.wValid && !bValidQ &&
                    (!wrIsPipe || inCount != inFull);  // Stall only on full pipe-in
  assign inPush   = wrAccept && wrIsPipe;              // Other addresses dropped

  always_ff @(posedge sysClk) begin
    if (rst) begin
      bValidQ <= 1'b0;
      bRespQ  <= respOkay;
    end else if (wrAccept) begin
      bValidQ <= 1'b1;
      bRespQ  <= wrIsPipe ? respOkay : respSlvErr;
    end else if (axiIn.bReady) begin
      bValidQ <= 1'b0;  // Response taken
    end
  end

  // Pipe-in queue
  assign cmdValid = (inCount != '0);
  assign cmdData  = inMem[inRdPtr];  // Head word
  assign inPop    = cmdValid && cmdReady;

  always_ff @(posedge sysClk) begin
    if (inPush) inMem[inWrPtr] <= cmdWord'(axiIn.wData);
  end

  always_ff @(posedge sysClk) begin
    if (rst) begin
      inWrPtr <= '0;
      inRdPtr <= '0;
      inCount <= '0;
    end else begin
      if (inPush) inWrPtr <= inWrPtr + 1'b1;  // Wraps, depth is 2^n
      if (inPop)  inRdPtr <= inRdPtr + 1'b1;
      case ({inPush, inPop})
        2'b10:   inCount <= inCount + 1'b1;
        2'b01:   inCount <= inCount - 1'b1;
        default: inCount <= inCount;          // Both or neither
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------------------
  assign arReady   = liveQ && !rValidQ;  // One read in flight
  assign rdFire    = arReady && axiIn.arValid;
  assign regRdIdx  = axiIn.arAddr[6:2];  // Word index inside either bank
  assign chanRdIdx = axiIn.arAddr[6:2];

  // Address decode for readback
  always_comb begin
    rdData = '0;
    rdResp = respSlvErr;  // Unmapped default
    rdPop  = 1'b0;
    if (axiIn.arAddr == addrPipeOut) begin
      if (outValid) begin
        rdData = outData;
        rdResp = respOkay;
        rdPop  = 1'b1;
      end
    end else if (axiIn.arAddr == addrStatus) begin
      rdData = 32'(outCount);
      rdResp = respOkay;
    end else if (axiIn.arAddr[11:7] == addrRegBase[11:7] && axiIn.arAddr[1:0] == 2'b00) begin
      rdData = 32'(regRdData);
      rdResp = respOkay;
    end else if (axiIn.arAddr[11:7] == addrChanBase[11:7] && axiIn.arAddr[1:0] == 2'b00) begin
      rdData = 32'(chanRdData);
      rdResp = respOkay;
    end
  end

  assign outPop = rdFire && rdPop;  // Pop only on an accepted read

  always_ff @(posedge sysClk) begin
    if (rst) begin
      rValidQ <= 1'b0;
    end else if (rdFire) begin
      rValidQ <= 1'b1;
    end else if (axiIn.rReady) begin
      rValidQ <= 1'b0;
    end
  end

  always_ff @(posedge sysClk) begin
    if (rdFire) begin
      rDataQ <= rdData;
      rRespQ <= rdResp;
    end
  end

  always_comb begin
    axiOut.awReady = wrAccept;
    axiOut.wReady  = wrAccept;  // Same pulse on both
    axiOut.bResp   = bRespQ;
    axiOut.bValid  = bValidQ;
    axiOut.arReady = arReady;
    axiOut.rData   = rDataQ;
    axiOut.rResp   = rRespQ;
    axiOut.rValid  = rValidQ;
  end

endmodule

/* bdHostCheck.sv */
`timescale 1ns/1ps

module bdHostCheck import bdHostPkg::*; (
  input  logic    sysClk,
  input  logic    rst,
  input  axilReq  axiIn,
  input  axilRsp  axiOut,
  input  logic    dnValid,
  input  downWord dnData,
  input  logic    dnReady,
  input  logic    upValid,
  input  upWord   upData,
  input  logic    upReady,
  output int      errCount,
  output int      dnPending
);

  logic [15:0] regModel  [32];
  logic [15:0] chanModel [32];
  downWord     dnQ [$];   // Sends not yet seen on the link
  logic [31:0] upQ [$];   // Tagged halves not yet popped
  logic [1:0]  expB;
  logic [1:0]  expR;
  logic [31:0] expRData;

  initial begin
    errCount  = 0;
    dnPending = 0;
    for (int i = 0; i < 32; i++) begin
      regModel[i]  = '0;
      chanModel[i] = '0;
    end
  end

  task automatic report(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    errCount++;
  endtask

  // ------------------------------------------------------------------------
  // Reference model of the command word
  // ------------------------------------------------------------------------
  task automatic applyCmd(input logic [31:0] w);
    downWord d;
    case (w[31:30])
      2'b10: if (w[28:24] != 5'd31) regModel[w[28:24]] = w[15:0];  // Reg 31 is a no-op
      2'b11: chanModel[w[28:24]] = w[15:0];
      2'b00: begin
        d.code    = w[29:24];
        d.payload = w[19:0];
        dnQ.push_back(d);
      end
      default: ;  // Dropped
    endcase
  endtask

  task automatic predictRead(input logic [11:0] a);
    expR     = respSlvErr;
    expRData = '0;
    if (a == 12'h004) begin
      if (upQ.size() > 0) begin
        expR     = respOkay;
        expRData = upQ.pop_front();  // Pop happens at the address handshake
      end
    end else if (a == 12'h008) begin
      expR     = respOkay;
      expRData = 32'(upQ.size());
    end else if (a[1:0] == 2'b00 && a >= 12'h100 && a < 12'h180) begin
      expR     = respOkay;
      expRData = {16'd0, regModel[a[6:2]]};
    end else if (a[1:0] == 2'b00 && a >= 12'h180 && a < 12'h200) begin
      expR     = respOkay;
      expRData = {16'd0, chanModel[a[6:2]]};
    end
  endtask

  always @(posedge sysClk) begin
    if (!rst) begin
      if (axiOut.wReady != axiOut.awReady)
        report($sformatf("wready %0d while awready %0d", axiOut.wReady, axiOut.awReady));
      if (axiOut.bValid && axiIn.bReady && axiOut.bResp != expB)
        report($sformatf("write resp %0d, expected %0d", axiOut.bResp, expB));
      if (axiIn.awValid && axiIn.wValid && axiOut.awReady) begin
        expB = (axiIn.awAddr == 12'h000) ? respOkay : respSlvErr;
        if (axiIn.awAddr == 12'h000) applyCmd(axiIn.wData);
      end
      if (axiOut.rValid && axiIn.rReady &&
          (axiOut.rResp != expR || axiOut.rData != expRData))
        report($sformatf("read got %h/%0d, expected %h/%0d",
                         axiOut.rData, axiOut.rResp, expRData, expR));
      if (axiIn.arValid && axiOut.arReady) predictRead(axiIn.arAddr);
      // Downstream order with no loss or duplicates
      if (dnValid && dnReady) begin
        if (dnQ.size() == 0)
          report($sformatf("unexpected downstream word %h", dnData));
        else if (dnData != dnQ[0])
          report($sformatf("dnData %h, expected %h", dnData, dnQ[0]));
        if (dnQ.size() > 0) void'(dnQ.pop_front());
      end
      if (upValid && upReady) begin
        upQ.push_back({8'hff, upData[23:0]});         // Low half first
        upQ.push_back({8'hff, 14'd0, upData[33:24]});
      end
      dnPending = dnQ.size();
    end
  end

endmodule

/* bdHostPkg.sv */
package bdHostPkg;

  // ------------------------------------------------------------------------
  // Command word, as written by the host to the pipe-in address
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    downSend = 2'b00,  // Code + payload to the board
    badKind  = 2'b01,  // Not a command, dropped
    regSet   = 2'b10,  // Config register write
    chanSet  = 2'b11   // Channel entry write
  } cmdKind;

  // Register / channel write layout
  typedef struct packed {
    cmdKind      kind;
    logic        spareA;
    logic [4:0]  idx;     // Register or channel number
    logic [7:0]  spareB;
    logic [15:0] data;
  } cfgFields;

  // Downstream send layout
  typedef struct packed {
    cmdKind      kind;
    logic [5:0]  code;
    logic [3:0]  spare;
    logic [19:0] payload;
  } sendFields;

  // Same 32 bits, two decodings
  typedef union packed {
    cfgFields  cfgView;
    sendFields sendView;
  } cmdWord;

  // ------------------------------------------------------------------------
  // Board links
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [5:0]  code;
    logic [19:0] payload;
  } downWord;  // 26 bits toward the board

  typedef logic [33:0] upWord;  // Raw word from the board

  localparam logic [7:0] tagByte = 8'hff;  // Top byte of every packed half

  // Host address map, byte addresses
  localparam logic [11:0] addrPipeIn   = 12'h000;
  localparam logic [11:0] addrPipeOut  = 12'h004;
  localparam logic [11:0] addrStatus   = 12'h008;
  localparam logic [11:0] addrRegBase  = 12'h100;
  localparam logic [11:0] addrChanBase = 12'h180;

  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

  localparam int cntBits = 16;  // Width of the pipe-out fill count

  // ------------------------------------------------------------------------
  // AXI4-Lite, host side bundles
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [11:0] awAddr;
    logic        awValid;
    logic [31:0] wData;
    logic        wValid;
    logic        bReady;
    logic [11:0] arAddr;
    logic        arValid;
    logic        rReady;
  } axilReq;

  typedef struct packed {
    logic        awReady;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
  } axilRsp;

endpackage

/* bdHostTop.f */
bdHostPkg.sv
axilPipeSlave.sv
cmdDecoder.sv
upPacker.sv
bdHostTop.sv
bdHostCheck.sv
bdHostTop_sva.sv
bdHostTop_tb.sv

/* bdHostTop.sv */
`timescale 1ns/1ps

module bdHostTop import bdHostPkg::*; #(
  parameter int inDepth  = 8,   // Pipe-in entries, power of two
  parameter int outDepth = 16   // Pipe-out entries, power of two
) (
  input  logic    sysClk,
  input  logic    rst,
  input  axilReq  axiIn,
  output axilRsp  axiOut,
  output logic    dnValid,
  output downWord dnData,
  input  logic    dnReady,
  input  logic    upValid,
  input  upWord   upData,
  output logic    upReady
);

  // ------------------------------------------------------------------------
  // Internal links
  // ------------------------------------------------------------------------
  logic               cmdValid;   // Slave to decoder
  cmdWord             cmdData;
  logic               cmdReady;
  logic [4:0]         regRdIdx;   // Bank readback
  logic [4:0]         chanRdIdx;
  logic [15:0]        regRdData;
  logic [15:0]        chanRdData;
  logic               outValid;   // Packer queue head
  logic [31:0]        outData;
  logic [cntBits-1:0] outCount;
  logic               outPop;

  // Host side
  axilPipeSlave #(.inDepth(inDepth)) uSlave (
    .sysClk, .rst, .axiIn, .axiOut,
    .cmdValid, .cmdData, .cmdReady,
    .regRdIdx, .chanRdIdx, .regRdData, .chanRdData,
    .outValid, .outData, .outCount, .outPop
  );

  // Command processing and downstream link
  cmdDecoder uDecoder (
    .sysClk, .rst,
    .cmdValid, .cmdData, .cmdReady,
    .regRdIdx, .chanRdIdx, .regRdData, .chanRdData,
    .dnValid, .dnData, .dnReady
  );

  // Upstream link into the pipe-out queue
  upPacker #(.outDepth(outDepth)) uPacker (
    .sysClk, .rst,
    .upValid, .upData, .upReady,
    .outValid, .outData, .outCount, .outPop
  );

endmodule

/* bdHostTop_sva.sv */
`timescale 1ns/1ps

module bdHostTop_sva import bdHostPkg::*; #(
  parameter int outDepth = 16
) (
  input logic               sysClk,
  input logic               rst,
  input axilReq             axiIn,
  input axilRsp             axiOut,
  input logic               dnValid,
  input downWord            dnData,
  input logic               dnReady,
  input logic               upValid,
  input upWord              upData,
  input logic               upReady,
  input logic [cntBits-1:0] outCount
);

  // Valid and data frozen on both links while stalled
  dnHold: assert property (@(posedge sysClk) disable iff (rst)
    dnValid && !dnReady |=> dnValid && $stable(dnData))
    else $error("dnValid or dnData changed while stalled");
  upHold: assert property (@(posedge sysClk) disable iff (rst)
    upValid && !upReady |=> upValid && $stable(upData))
    else $error("upValid or upData changed while stalled");

  bHold: assert property (@(posedge sysClk) disable iff (rst)
    axiOut.bValid && !axiIn.bReady |=> axiOut.bValid)
    else $error("bvalid dropped before bready");

  // No push into a full pipe-out queue
  outBound: assert property (@(posedge sysClk) disable iff (rst)
    outCount <= cntBits'(outDepth))
    else $error("pipe-out count above depth");

endmodule

bind bdHostTop bdHostTop_sva #(.outDepth(outDepth)) uSva (
  .sysClk, .rst, .axiIn, .axiOut, .dnValid, .dnData, .dnReady,
  .upValid, .upData, .upReady, .outCount
);

/* bdHostTop_tb.sv */
`timescale 1ns/1ps

module bdHostTop_tb import bdHostPkg::*; ();

  localparam int opBudget    = 40;                       // Worst cycles per transfer
  localparam int opTotal     = 104 + 60 + 124 + 100 + 10;  // Transfers over all tests
  localparam int limitCycles = 2 * opBudget * opTotal;

  logic        sysClk;
  logic        rst;
  axilReq      axiIn;
  axilRsp      axiOut;
  logic        dnValid;
  downWord     dnData;
  logic        dnReady;
  logic        upValid;
  upWord       upData;
  logic        upReady;
  int          checkErrs;
  int          dnPending;
  int          errMark;
  int          cycles;
  int          testNum;
  logic [31:0] rndState;
  logic [31:0] dnRnd;
  logic        stretchMode;  // Long dnReady low phases
  int          stretchCnt;

  bdHostTop u_dut (
    .sysClk, .rst, .axiIn, .axiOut, .dnValid, .dnData, .dnReady,
    .upValid, .upData, .upReady
  );

  bdHostCheck u_check (
    .sysClk, .rst, .axiIn, .axiOut, .dnValid, .dnData, .dnReady,
    .upValid, .upData, .upReady, .errCount(checkErrs), .dnPending
  );

  initial sysClk = 1'b0;
  always #50 sysClk = ~sysClk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function logic [31:0] nextRnd();
    rndState = xorshift(rndState);
    return rndState;
  endfunction

  // Board sink with 30 percent stalls or long stretches
  always @(negedge sysClk) begin
    dnRnd = xorshift(dnRnd);
    stretchCnt = (stretchCnt + 1) % 36;
    if (rst) dnReady = 1'b0;
    else if (stretchMode) dnReady = (stretchCnt >= 30);
    else dnReady = (dnRnd % 100) >= 30;
  end

  always @(posedge sysClk) begin
    cycles++;
    if (cycles > limitCycles) begin
      $display("Timeout: run did not finish within %0d cycles", limitCycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // AXI master and board source entered on a falling edge
  // ------------------------------------------------------------------------
  task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data);
    logic        done;
    logic [31:0] hold;
    done = 1'b0;
    hold = nextRnd();
    axiIn.awAddr  = addr;
    axiIn.wData   = data;
    axiIn.awValid = 1'b1;
    axiIn.wValid  = 1'b1;
    while (!done) begin
      #10 done = axiOut.awReady;  // Settled mid cycle
      @(negedge sysClk);
    end
    axiIn.awValid = 1'b0;
    axiIn.wValid  = 1'b0;
    while (!axiOut.bValid) @(negedge sysClk);
    repeat (int'(hold[1:0]) % 3) @(negedge sysClk);  // Host slow to take the response
    axiIn.bReady = 1'b1;
    @(negedge sysClk);
    axiIn.bReady = 1'b0;
  endtask

  task automatic axiRead(input logic [11:0] addr);
    logic done;
    done = 1'b0;
    axiIn.arAddr  = addr;
    axiIn.arValid = 1'b1;
    while (!done) begin
      #10 done = axiOut.arReady;
      @(negedge sysClk);
    end
    axiIn.arValid = 1'b0;
    while (!axiOut.rValid) @(negedge sysClk);
    @(negedge sysClk);
  endtask

  task automatic sendUp(input upWord w, input int gap);
    logic done;
    done = 1'b0;
    repeat (gap) @(negedge sysClk);
    upValid = 1'b1;
    upData  = w;
    while (!done) begin
      #10 done = upReady;
      @(negedge sysClk);
    end
    upValid = 1'b0;
  endtask

  task automatic drainDown();
    stretchMode = 1'b0;
    while (dnPending != 0) @(negedge sysClk);
    repeat (10) @(negedge sysClk);  // Pipe-in may still hold config words
  endtask

  task automatic endTest(input string name);
    int errs;
    errs = checkErrs - errMark;
    testNum++;
    if (errs == 0) $display("Test %0d %s: passed", testNum, name);
    else $display("Test %0d %s: failed with %0d errors", testNum, name, errs);
    errMark = checkErrs;
  endtask

  initial begin
    logic [31:0] r;
    rndState = 32'hbebf4b3e;
    dnRnd = xorshift(32'hbebf4b3e ^ 32'h5a5a5a5a);
    axiIn = '0;
    axiIn.rReady = 1'b1;
    upValid = 1'b0;
    upData = '0;
    dnReady = 1'b0;
    stretchMode = 1'b0;
    stretchCnt = 0;
    errMark = 0;
    cycles = 0;
    testNum = 0;
    rst = 1'b1;
    repeat (5) @(posedge sysClk);
    @(negedge sysClk);
    rst = 1'b0;

    // Configuration writes then full readback
    for (int i = 0; i < 40; i++) begin
      r = nextRnd();
      axiWrite(12'h000, {1'b1, r[31], 1'b0, r[28:24], 8'h00, r[15:0]});
    end
    repeat (12) @(negedge sysClk);  // Pipe-in drains one per cycle
    for (int i = 0; i < 64; i++) axiRead(12'h100 + 12'(4 * i));
    endTest("configuration");

    for (int i = 0; i < 60; i++) begin
      r = nextRnd();
      axiWrite(12'h000, {2'b00, r[29:0]});
    end
    drainDown();
    endTest("downstream");

    // All kinds mixed under long downstream stalls
    stretchMode = 1'b1;
    for (int i = 0; i < 60; i++) axiWrite(12'h000, nextRnd());
    drainDown();
    for (int i = 0; i < 64; i++) axiRead(12'h100 + 12'(4 * i));
    endTest("mixed stream");

    // Groups of four words, gap 0 hits the busy half cycle
    for (int g = 0; g < 5; g++) begin
      for (int i = 0; i < 4; i++) begin
        r = nextRnd();
        sendUp({r[1:0], nextRnd()}, int'(r[5:2] % 4));
      end
      repeat (3) @(negedge sysClk);  // High half lands one cycle late
      for (int i = 0; i < 8; i++) begin
        axiRead(12'h008);
        axiRead(12'h004);
      end
    end
    endTest("upstream");

    axiWrite(12'h004, 32'h8100_1234);
    axiWrite(12'h104, 32'h0000_beef);
    axiWrite(12'h200, 32'h0000_0001);
    axiRead(12'h00c);
    axiRead(12'h300);
    axiRead(12'h102);
    axiRead(12'h004);  // Empty pipe-out
    axiRead(12'h008);
    axiRead(12'h104);
    axiRead(12'h184);
    endTest("errors");

    $display("Tests run %0d, errors %0d", testNum, checkErrs);
    if (checkErrs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* cmdDecoder.sv */
`timescale 1ns/1ps

module cmdDecoder import bdHostPkg::*; (
  input  logic        sysClk,
  input  logic        rst,
  input  logic        cmdValid,
  input  cmdWord      cmdData,
  output logic        cmdReady,
  input  logic [4:0]  regRdIdx,
  input  logic [4:0]  chanRdIdx,
  output logic [15:0] regRdData,
  output logic [15:0] chanRdData,
  output logic        dnValid,
  output downWord     dnData,
  input  logic        dnReady
);

  localparam logic [4:0] nopIdx = 5'd31;  // Padding target, never stored

  logic [15:0] regBank  [32];
  logic [15:0] chanBank [32];
  logic        cmdTake;
  cmdKind      kind;
  logic        isReg;
  logic        isChan;
  logic        isSend;

  // ------------------------------------------------------------------------
  // Command acceptance
  // ------------------------------------------------------------------------
  // Output slot frees in the same cycle it is taken downstream
  assign cmdReady = !dnValid || dnReady;
  assign cmdTake  = cmdValid && cmdReady;

  assign kind   = cmdData.cfgView.kind;  // Kind sits at the top in both views
  assign isReg  = cmdTake && (kind == regSet);
  assign isChan = cmdTake && (kind == chanSet);
  assign isSend = cmdTake && (kind == downSend);
  // badKind falls through, word is consumed and nothing else happens

  // Config banks
  always_ff @(posedge sysClk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regBank[i]  <= '0;
        chanBank[i] <= '0;
      end
    end else begin
      if (isReg && cmdData.cfgView.idx != nopIdx)
        regBank[cmdData.cfgView.idx] <= cmdData.cfgView.data;
      if (isChan)
        chanBank[cmdData.cfgView.idx] <= cmdData.cfgView.data;  // All 32 usable
    end
  end

  assign regRdData  = regBank[regRdIdx];    // Readback lookups for the slave
  assign chanRdData = chanBank[chanRdIdx];

  // ------------------------------------------------------------------------
  // Downstream output register
  // ------------------------------------------------------------------------
  always_ff @(posedge sysClk) begin
    if (rst) begin
      dnValid <= 1'b0;
    end else if (isSend) begin
      dnValid <= 1'b1;  // Reload, even back to back
    end else if (dnReady) begin
      dnValid <= 1'b0;
    end
  end

  // Payload, loaded only on a send
  always_ff @(posedge sysClk) begin
    if (isSend) begin
      dnData.code    <= cmdData.sendView.code;
      dnData.payload <= cmdData.sendView.payload;
    end
  end

endmodule

/* upPacker.sv */
`timescale 1ns/1ps

module upPacker import bdHostPkg::*; #(
  parameter int outDepth = 16
) (
  input  logic               sysClk,
  input  logic               rst,
  input  logic               upValid,
  input  upWord              upData,
  output logic               upReady,
  output logic               outValid,
  output logic [31:0]        outData,
  output logic [cntBits-1:0] outCount,
  input  logic               outPop
);

  localparam int ptrW = $clog2(outDepth);
  localparam logic [ptrW:0] roomLimit = (ptrW+1)'(outDepth - 2);  // Two free slots

  logic            liveQ;
  logic [31:0]     outMem [outDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;
  logic            upFire;
  logic            halfPending;  // High word still waiting
  logic [31:0]     hiBuf;
  logic            outPush;
  logic            outTake;
  logic [31:0]     pushData;

  always_ff @(posedge sysClk) begin
    if (rst) liveQ <= 1'b0;
    else     liveQ <= 1'b1;
  end

  // ------------------------------------------------------------------------
  // Split into tagged halves
  // ------------------------------------------------------------------------
  assign upReady = liveQ && !halfPending && (count <= roomLimit);
  assign upFire  = upValid && upReady;

  always_ff @(posedge sysClk) begin
    if (rst)         halfPending <= 1'b0;
    else if (upFire) halfPending <= 1'b1;
    else             halfPending <= 1'b0;  // High half goes out next cycle
  end

  always_ff @(posedge sysClk) begin
    if (upFire) hiBuf <= {tagByte, 14'd0, upData[33:24]};
  end

  // Low half first, high half one cycle later
  assign outPush  = upFire || halfPending;
  assign pushData = halfPending ? hiBuf : {tagByte, upData[23:0]};

  // Pipe-out queue
  assign outValid = (count != '0);
  assign outData  = outMem[rdPtr];
  assign outTake  = outPop && outValid;
  assign outCount = cntBits'(count);

  always_ff @(posedge sysClk) begin
    if (outPush) outMem[wrPtr] <= pushData;
  end

  always_ff @(posedge sysClk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (outPush) wrPtr <= wrPtr + 1'b1;
      if (outTake) rdPtr <= rdPtr + 1'b1;
      case ({outPush, outTake})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
